//--- hw/scan_ctrl.sv
// Packet register with scan and parallel paths, operation decode and access sequencer
`timescale 1ns/10ps
`default_nettype none

module scan_ctrl #(
   parameter int DATA_W    = 32,
   parameter int ADDR_W    = 11,
   parameter int NUM_CHIPS = 4
) (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic                       scan_en_i,
   input  wire logic                       scan_i,
   input  wire logic                       in_load_i,
   input  wire logic [sram_pkg::PKT_W-1:0] par_data_i,
   input  wire logic                       sram_load_i,
   input  wire logic                       global_csb_i,
   output      logic                       scan_o,
   output      logic [sram_pkg::PKT_W-1:0] par_data_o,
   sram_port_if.controller                 mem
);

   localparam int PKT_W = sram_pkg::PKT_W;

   logic [PKT_W-1:0]      pkt_q;
   sram_pkg::sram_pkt_t   pkt_w;
   sram_pkg::ctrl_state_e state_q;
   sram_pkg::ctrl_state_e state_d;
   logic                  start_w;
   logic [NUM_CHIPS-1:0]  chip_oh_w;
   logic [NUM_CHIPS-1:0]  csb0_d;
   logic [NUM_CHIPS-1:0]  csb1_d;
   logic                  web0_d;

   assign pkt_w      = sram_pkg::sram_pkt_t'(pkt_q);
   assign par_data_o = pkt_q;
   assign scan_o     = pkt_q[PKT_W-1];

   // Load strobe only counts when idle and no packet load is under way
   assign start_w = sram_load_i && !in_load_i && !scan_en_i &&
                    (state_q == sram_pkg::ST_IDLE);

   // Parallel load wins over shifting and result capture comes last
   always_ff @(posedge clk) begin
      if (!rstn) begin
         pkt_q <= '0;
      end else if (in_load_i) begin
         pkt_q <= par_data_i;
      end else if (scan_en_i) begin
         pkt_q <= {pkt_q[PKT_W-2:0], scan_i};
      end else if (state_q == sram_pkg::ST_CAPTURE) begin
         pkt_q <= mem.dout;
      end
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         sram_pkg::ST_IDLE:    if (start_w) state_d = sram_pkg::ST_ACCESS;
         sram_pkg::ST_ACCESS:  state_d = sram_pkg::ST_WAIT;
         sram_pkg::ST_WAIT:    state_d = sram_pkg::ST_CAPTURE;
         sram_pkg::ST_CAPTURE: state_d = sram_pkg::ST_IDLE;
         default:              state_d = sram_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q <= sram_pkg::ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Chip numbers beyond the bank select nothing
   assign chip_oh_w = NUM_CHIPS'(1) << pkt_w.chip;

   always_comb begin
      csb0_d = '1;
      csb1_d = '1;
      web0_d = 1'b1;
      if (!global_csb_i) begin
         case (pkt_w.op)
            sram_pkg::OP_WRITE: begin
               csb0_d = ~chip_oh_w;
               csb1_d = ~chip_oh_w;
               web0_d = 1'b0;
            end
            sram_pkg::OP_READ0: begin
               csb0_d = ~chip_oh_w;
            end
            sram_pkg::OP_READ_BOTH: begin
               csb0_d = ~chip_oh_w;
               csb1_d = ~chip_oh_w;
            end
            default: begin
               csb0_d = '1;
            end
         endcase
      end
   end

   // Selects are low only for the ST_ACCESS cycle
   always_ff @(posedge clk) begin
      if (!rstn) begin
         mem.csb0 <= '1;
         mem.csb1 <= '1;
         mem.web0 <= 1'b1;
      end else if (start_w) begin
         mem.csb0 <= csb0_d;
         mem.csb1 <= csb1_d;
         mem.web0 <= web0_d;
      end else begin
         mem.csb0 <= '1;
         mem.csb1 <= '1;
         mem.web0 <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (start_w) begin
         mem.wmask0 <= (DATA_W/8)'(pkt_w.wmask);
         mem.addr0  <= ADDR_W'(pkt_w.addr0);
         mem.addr1  <= ADDR_W'(pkt_w.addr1);
         mem.din0   <= DATA_W'(pkt_w.din);
      end
   end

endmodule

`default_nettype wire

//--- hw/sram_bank.sv
// Bank of macros with growing depth, per-chip capture registers and selected-chip read mux
`timescale 1ns/10ps
`default_nettype none

module sram_bank #(
   parameter int DATA_W    = 32,
   parameter int ADDR_W    = 11,
   parameter int NUM_CHIPS = 4
) (
   input wire logic clk,
   input wire logic rstn,
   sram_port_if.bank mem
);

   localparam int SEL_W = sram_pkg::CHIP_W;

   logic [DATA_W-1:0]    dout0_w [NUM_CHIPS];
   logic [DATA_W-1:0]    dout1_w [NUM_CHIPS];
   logic [DATA_W-1:0]    cap0_q  [NUM_CHIPS];
   logic [DATA_W-1:0]    cap1_q  [NUM_CHIPS];
   logic [NUM_CHIPS-1:0] act_w;
   logic [SEL_W-1:0]     act_idx_w;
   logic [SEL_W-1:0]     sel_q;
   logic                 sel_vld_q;
   logic [SEL_W-1:0]     cap_sel_q;
   logic                 cap_vld_q;

   for (genvar i = 0; i < NUM_CHIPS; i++) begin : g_chip
      // Each chip doubles the depth of the one before, limited by the address bus
      localparam int ADDR_BITS = (8 + i > ADDR_W) ? ADDR_W : 8 + i;

      sram_macro #(
         .ADDR_BITS (ADDR_BITS),
         .DATA_W    (DATA_W)
      ) u_macro (
         .clk      (clk),
         .csb0_i   (mem.csb0[i]),
         .web0_i   (mem.web0),
         .wmask0_i (mem.wmask0),
         .addr0_i  (mem.addr0[ADDR_BITS-1:0]),
         .din0_i   (mem.din0),
         .dout0_o  (dout0_w[i]),
         .csb1_i   (mem.csb1[i]),
         .addr1_i  (mem.addr1[ADDR_BITS-1:0]),
         .dout1_o  (dout1_w[i])
      );

      // Hold macro outputs one cycle after they register
      always_ff @(posedge clk) begin
         if (!rstn) begin
            cap0_q[i] <= '0;
            cap1_q[i] <= '0;
         end else begin
            cap0_q[i] <= dout0_w[i];
            cap1_q[i] <= dout1_w[i];
         end
      end
   end

   // A chip is active when either of its ports is selected
   assign act_w = ~mem.csb0 | ~mem.csb1;

   always_comb begin
      act_idx_w = '0;
      for (int c = 0; c < NUM_CHIPS; c++) begin
         if (act_w[c]) begin
            act_idx_w = SEL_W'(c);
         end
      end
   end

   // Chip index follows the data through macro output and capture stages
   always_ff @(posedge clk) begin
      if (!rstn) begin
         sel_q     <= '0;
         sel_vld_q <= 1'b0;
         cap_sel_q <= '0;
         cap_vld_q <= 1'b0;
      end else begin
         sel_q     <= act_idx_w;
         sel_vld_q <= |act_w;
         cap_sel_q <= sel_q;
         cap_vld_q <= sel_vld_q;
      end
   end

   always_comb begin
      mem.dout = '0;
      if (cap_vld_q) begin
         mem.dout.dout0 = cap0_q[cap_sel_q];
         mem.dout.dout1 = cap1_q[cap_sel_q];
      end
   end

endmodule

`default_nettype wire

//--- hw/sram_macro.sv
// Behavioral dual-port SRAM with one read/write port, one read port and byte write mask
`timescale 1ns/10ps
`default_nettype none

module sram_macro #(
   parameter int ADDR_BITS = 8,
   parameter int DATA_W    = 32
) (
   input  wire logic                  clk,
   // Read/write port
   input  wire logic                  csb0_i,
   input  wire logic                  web0_i,
   input  wire logic [DATA_W/8-1:0]   wmask0_i,
   input  wire logic [ADDR_BITS-1:0]  addr0_i,
   input  wire logic [DATA_W-1:0]     din0_i,
   output      logic [DATA_W-1:0]     dout0_o,
   // Read-only port
   input  wire logic                  csb1_i,
   input  wire logic [ADDR_BITS-1:0]  addr1_i,
   output      logic [DATA_W-1:0]     dout1_o
);

   localparam int DEPTH  = 1 << ADDR_BITS;
   localparam int LANES  = DATA_W / 8;

   logic [DATA_W-1:0] mem_q [DEPTH];

   // Masked write, one byte lane per mask bit
   always_ff @(posedge clk) begin
      if (!csb0_i && !web0_i) begin
         for (int b = 0; b < LANES; b++) begin
            if (wmask0_i[b]) begin
               mem_q[addr0_i][b*8 +: 8] <= din0_i[b*8 +: 8];
            end
         end
      end
   end

   // Port 0 output, zero when the port does not read
   always_ff @(posedge clk) begin
      if (!csb0_i && web0_i) begin
         dout0_o <= mem_q[addr0_i];
      end else begin
         dout0_o <= '0;
      end
   end

   // Port 1 sees the old word when port 0 writes the same address
   always_ff @(posedge clk) begin
      if (!csb1_i) begin
         dout1_o <= mem_q[addr1_i];
      end else begin
         dout1_o <= '0;
      end
   end

endmodule

`default_nettype wire

//--- hw/sram_pkg.sv
// Widths, operation and sequencer enums, command packet and result structs
`default_nettype none

package sram_pkg;

   // Array dimensions shared by controller and bank
   localparam int NUM_CHIPS = 4;
   localparam int DATA_W    = 32;
   // Enough for the deepest macro of 2048 words
   localparam int ADDR_W    = 11;
   localparam int MASK_W    = DATA_W / 8;
   localparam int PKT_W     = 64;
   localparam int CHIP_W    = 2;

   typedef enum logic [1:0] {
      OP_NOP       = 2'd0,
      OP_WRITE     = 2'd1,
      OP_READ0     = 2'd2,
      OP_READ_BOTH = 2'd3
   } sram_op_e;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ACCESS  = 2'd1,
      ST_WAIT    = 2'd2,
      ST_CAPTURE = 2'd3
   } ctrl_state_e;

   // Command packet, MSB first as it leaves the scan chain
   typedef struct packed {
      logic [1:0]        spare;
      logic [CHIP_W-1:0] chip;
      sram_op_e          op;
      logic [MASK_W-1:0] wmask;
      logic [ADDR_W-1:0] addr0;
      logic [ADDR_W-1:0] addr1;
      logic [DATA_W-1:0] din;
   } sram_pkt_t;

   // Read data placed back into the packet register
   typedef struct packed {
      logic [DATA_W-1:0] dout0;
      logic [DATA_W-1:0] dout1;
   } sram_result_t;

endpackage

`default_nettype wire

//--- hw/sram_port_if.sv
// Shared SRAM select, control, address and data lines with controller and bank modports
`timescale 1ns/10ps
`default_nettype none

interface sram_port_if #(
   parameter int DATA_W    = 32,
   parameter int ADDR_W    = 11,
   parameter int NUM_CHIPS = 4
);

   // One active-low select per chip and port
   logic [NUM_CHIPS-1:0]  csb0;
   logic [NUM_CHIPS-1:0]  csb1;
   logic                  web0;
   logic [DATA_W/8-1:0]   wmask0;
   logic [ADDR_W-1:0]     addr0;
   logic [ADDR_W-1:0]     addr1;
   logic [DATA_W-1:0]     din0;
   // Captured read data of the last selected chip
   sram_pkg::sram_result_t dout;

   modport controller (
      output csb0, csb1, web0, wmask0, addr0, addr1, din0,
      input  dout
   );

   modport bank (
      input  csb0, csb1, web0, wmask0, addr0, addr1, din0,
      output dout
   );

endinterface

`default_nettype wire

//--- hw/sram_test_top.sv
// Top level joining the scan controller and the SRAM bank over the shared port interface
`timescale 1ns/10ps
`default_nettype none

module sram_test_top #(
   parameter int DATA_W    = sram_pkg::DATA_W,
   parameter int ADDR_W    = sram_pkg::ADDR_W,
   parameter int NUM_CHIPS = sram_pkg::NUM_CHIPS
) (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic                       scan_en_i,
   input  wire logic                       scan_i,
   input  wire logic                       in_load_i,
   input  wire logic [sram_pkg::PKT_W-1:0] par_data_i,
   input  wire logic                       sram_load_i,
   input  wire logic                       global_csb_i,
   output      logic                       scan_o,
   output      logic [sram_pkg::PKT_W-1:0] par_data_o
);

   sram_port_if #(
      .DATA_W    (DATA_W),
      .ADDR_W    (ADDR_W),
      .NUM_CHIPS (NUM_CHIPS)
   ) mem_if ();

   scan_ctrl #(
      .DATA_W    (DATA_W),
      .ADDR_W    (ADDR_W),
      .NUM_CHIPS (NUM_CHIPS)
   ) u_scan_ctrl (
      .clk          (clk),
      .rstn         (rstn),
      .scan_en_i    (scan_en_i),
      .scan_i       (scan_i),
      .in_load_i    (in_load_i),
      .par_data_i   (par_data_i),
      .sram_load_i  (sram_load_i),
      .global_csb_i (global_csb_i),
      .scan_o       (scan_o),
      .par_data_o   (par_data_o),
      .mem          (mem_if.controller)
   );

   sram_bank #(
      .DATA_W    (DATA_W),
      .ADDR_W    (ADDR_W),
      .NUM_CHIPS (NUM_CHIPS)
   ) u_sram_bank (
      .clk  (clk),
      .rstn (rstn),
      .mem  (mem_if.bank)
   );

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module sram_test_tb -f tb.f -Mdir obj_dir
./obj_dir/Vsram_test_tb > sim.log 2>&1 || true
cat sim.log
# A run that stops before its status line counts as failed too
if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"

//--- tb.f
hw/sram_pkg.sv
hw/sram_port_if.sv
hw/sram_macro.sv
hw/sram_bank.sv
hw/scan_ctrl.sv
hw/sram_test_top.sv
verif/sram_test_checker.sv
verif/sram_test_tb.sv

//--- verif/sram_test_checker.sv
// Assertions on the controller's memory selects, write enable and sequencer, bound to scan_ctrl
`timescale 1ns/10ps
`default_nettype none

module sram_test_checker #(
   parameter int NUM_CHIPS = 4
) (
   input wire logic                 clk,
   input wire logic                 rstn,
   input wire logic                 global_csb_i,
   input wire logic                 start_i,
   input wire logic [1:0]           state_i,
   input wire logic [NUM_CHIPS-1:0] csb0_i,
   input wire logic [NUM_CHIPS-1:0] csb1_i,
   input wire logic                 web0_i
);

   a_one_chip: assert property (@(posedge clk) disable iff (!rstn) $onehot0(~csb0_i))
      else $error("more than one chip selected on port 0");

   // Disabled access keeps every select high in ST_ACCESS
   a_global_off: assert property (@(posedge clk) disable iff (!rstn)
      start_i && global_csb_i |=> (&csb0_i) && (&csb1_i))
      else $error("select low while global chip select was high");

   a_web_sel: assert property (@(posedge clk) disable iff (!rstn) !web0_i |-> !(&csb0_i))
      else $error("write enable low without a port 0 select");

   a_sel_release: assert property (@(posedge clk) disable iff (!rstn)
      state_i == sram_pkg::ST_ACCESS |=> (&csb0_i) && (&csb1_i))
      else $error("selects still low after the access cycle");

endmodule

bind scan_ctrl sram_test_checker #(
   .NUM_CHIPS (NUM_CHIPS)
) u_checker (
   .clk          (clk),
   .rstn         (rstn),
   .global_csb_i (global_csb_i),
   .start_i      (start_w),
   .state_i      (state_q),
   .csb0_i       (mem.csb0),
   .csb1_i       (mem.csb1),
   .web0_i       (mem.web0)
);

`default_nettype wire

//--- verif/sram_test_tb.sv
// Testbench with clock, reset, stimulus table, reference memory model, compare tasks and watchdog
`timescale 1ns/10ps
`default_nettype none

module sram_test_tb;

   localparam int CLK_PERIOD = 10;
   localparam int PKT_W      = sram_pkg::PKT_W;
   localparam int DATA_W     = sram_pkg::DATA_W;
   localparam int ADDR_W     = sram_pkg::ADDR_W;
   localparam int MASK_W     = sram_pkg::MASK_W;
   localparam int NUM_CHIPS  = sram_pkg::NUM_CHIPS;
   // Cycles from the strobe edge to the result in the packet register
   localparam int ACCESS_LAT = 3;

   typedef struct packed {
      sram_pkg::sram_pkt_t pkt;
      logic                load_scan;
      logic                read_scan;
      logic                gcsb;
   } test_t;

   logic             clk = 1'b0;
   logic             rstn;
   logic             scan_en;
   logic             scan_bit;
   logic             in_load;
   logic [PKT_W-1:0] par_in;
   logic             sram_load;
   logic             global_csb;
   logic             scan_out;
   logic [PKT_W-1:0] par_out;

   test_t             tbl[$];
   // One word store per chip keyed by wrapped address
   logic [DATA_W-1:0] ref_mem [NUM_CHIPS][int];
   integer            seed;
   int                errors = 0;
   int                checks = 0;
   bit                table_ready = 1'b0;

   sram_test_top #(
      .DATA_W    (DATA_W),
      .ADDR_W    (ADDR_W),
      .NUM_CHIPS (NUM_CHIPS)
   ) DUT (
      .clk          (clk),
      .rstn         (rstn),
      .scan_en_i    (scan_en),
      .scan_i       (scan_bit),
      .in_load_i    (in_load),
      .par_data_i   (par_in),
      .sram_load_i  (sram_load),
      .global_csb_i (global_csb),
      .scan_o       (scan_out),
      .par_data_o   (par_out)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Chip c holds 2**(8+c) words
   function automatic int wrap_addr(input int chip, input logic [ADDR_W-1:0] addr);
      return int'(addr) & ((1 << (8 + chip)) - 1);
   endfunction

   task automatic add_entry(input logic [1:0] chip, input sram_pkg::sram_op_e op,
                            input logic [MASK_W-1:0] wmask, input logic [ADDR_W-1:0] a0,
                            input logic [ADDR_W-1:0] a1, input logic load_scan,
                            input logic read_scan, input logic gcsb);
      test_t t;
      t           = '0;
      t.pkt.chip  = chip;
      t.pkt.op    = op;
      t.pkt.wmask = wmask;
      t.pkt.addr0 = a0;
      t.pkt.addr1 = a1;
      t.pkt.din   = $random(seed);
      t.load_scan = load_scan;
      t.read_scan = read_scan;
      t.gcsb      = gcsb;
      tbl.push_back(t);
   endtask

   task automatic build_table();
      // Full-mask write then single-port read on every chip
      for (int c = 0; c < NUM_CHIPS; c++) begin
         add_entry(2'(c), sram_pkg::OP_WRITE, 4'hF, 11'(16 + c), 11'(16 + c), 1'b0, 1'b0, 1'b0);
         add_entry(2'(c), sram_pkg::OP_READ0, 4'h0, 11'(16 + c), 11'h000, 1'b0, 1'b0, 1'b0);
      end
      // Partial byte mask on chip 1
      add_entry(2'd1, sram_pkg::OP_WRITE, 4'hF, 11'h1F0, 11'h011, 1'b0, 1'b0, 1'b0);
      add_entry(2'd1, sram_pkg::OP_WRITE, 4'h5, 11'h011, 11'h1F0, 1'b0, 1'b0, 1'b0);
      add_entry(2'd1, sram_pkg::OP_READ_BOTH, 4'h0, 11'h011, 11'h1F0, 1'b0, 1'b0, 1'b0);
      // Addresses past the depth of chips 0 and 2 alias
      add_entry(2'd0, sram_pkg::OP_WRITE, 4'hF, 11'h1A5, 11'h010, 1'b0, 1'b0, 1'b0);
      add_entry(2'd0, sram_pkg::OP_READ_BOTH, 4'h0, 11'h0A5, 11'h010, 1'b0, 1'b0, 1'b0);
      add_entry(2'd2, sram_pkg::OP_WRITE, 4'hF, 11'h7FF, 11'h012, 1'b0, 1'b0, 1'b0);
      add_entry(2'd2, sram_pkg::OP_READ0, 4'h0, 11'h3FF, 11'h000, 1'b0, 1'b0, 1'b0);
      // Serial load and readout against parallel ones
      add_entry(2'd3, sram_pkg::OP_WRITE, 4'hF, 11'h456, 11'h013, 1'b1, 1'b1, 1'b0);
      add_entry(2'd3, sram_pkg::OP_READ_BOTH, 4'h0, 11'h456, 11'h013, 1'b1, 1'b1, 1'b0);
      add_entry(2'd3, sram_pkg::OP_READ_BOTH, 4'h0, 11'h456, 11'h013, 1'b0, 1'b1, 1'b0);
      add_entry(2'd3, sram_pkg::OP_READ_BOTH, 4'h0, 11'h456, 11'h013, 1'b0, 1'b0, 1'b0);
      // Global disable and NOP
      add_entry(2'd2, sram_pkg::OP_WRITE, 4'hF, 11'h012, 11'h012, 1'b0, 1'b0, 1'b1);
      add_entry(2'd2, sram_pkg::OP_READ0, 4'h0, 11'h012, 11'h000, 1'b0, 1'b0, 1'b0);
      add_entry(2'd0, sram_pkg::OP_NOP, 4'hF, 11'h010, 11'h010, 1'b0, 1'b0, 1'b0);
      add_entry(2'd1, sram_pkg::OP_READ_BOTH, 4'h0, 11'h011, 11'h1F0, 1'b0, 1'b1, 1'b1);
   endtask

   // Expected result and model update
   // A field is unknown if its word was never written
   task automatic predict(input test_t t, output sram_pkg::sram_result_t exp,
                          output bit known0, output bit known1);
      int                c;
      int                a0;
      int                a1;
      logic [DATA_W-1:0] word;
      c      = int'(t.pkt.chip);
      a0     = wrap_addr(c, t.pkt.addr0);
      a1     = wrap_addr(c, t.pkt.addr1);
      exp    = '0;
      known0 = 1'b1;
      known1 = 1'b1;
      if (!t.gcsb) begin
         if (t.pkt.op == sram_pkg::OP_READ0 || t.pkt.op == sram_pkg::OP_READ_BOTH) begin
            known0 = (ref_mem[c].exists(a0) != 0);
            if (known0) begin
               exp.dout0 = ref_mem[c][a0];
            end
         end
         if (t.pkt.op == sram_pkg::OP_WRITE || t.pkt.op == sram_pkg::OP_READ_BOTH) begin
            known1 = (ref_mem[c].exists(a1) != 0);
            if (known1) begin
               exp.dout1 = ref_mem[c][a1];
            end
         end
         // Port 1 read above sees the word before this write
         if (t.pkt.op == sram_pkg::OP_WRITE) begin
            if (ref_mem[c].exists(a0) != 0) begin
               word = ref_mem[c][a0];
               for (int b = 0; b < MASK_W; b++) begin
                  if (t.pkt.wmask[b]) begin
                     word[b*8 +: 8] = t.pkt.din[b*8 +: 8];
                  end
               end
               ref_mem[c][a0] = word;
            end else if (&t.pkt.wmask) begin
               ref_mem[c][a0] = t.pkt.din;
            end
         end
      end
   endtask

   task automatic check_result(input sram_pkg::sram_result_t got,
                               input sram_pkg::sram_result_t exp,
                               input bit known0, input bit known1, input int idx);
      checks++;
      if ((known0 && got.dout0 !== exp.dout0) || (known1 && got.dout1 !== exp.dout1)) begin
         errors++;
         $display("error at %0t: entry %0d result %h, expected %h", $time, idx, got, exp);
      end
   endtask

   task automatic check_scan_bit(input logic got, input logic exp, input int idx,
                                 input int bit_no);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: entry %0d scan bit %0d is %b, expected %b",
                  $time, idx, bit_no, got, exp);
      end
   endtask

   task automatic load_parallel(input sram_pkg::sram_pkt_t pkt);
      par_in  = pkt;
      in_load = 1'b1;
      @(negedge clk);
      in_load = 1'b0;
   endtask

   // MSB first, so the packet is in place after the last shift
   task automatic load_serial(input sram_pkg::sram_pkt_t pkt);
      logic [PKT_W-1:0] raw;
      raw     = pkt;
      scan_en = 1'b1;
      for (int b = PKT_W - 1; b >= 0; b--) begin
         scan_bit = raw[b];
         @(negedge clk);
      end
      scan_en  = 1'b0;
      scan_bit = 1'b0;
   endtask

   task automatic start_access();
      sram_load = 1'b1;
      @(negedge clk);
      sram_load = 1'b0;
      repeat (ACCESS_LAT) @(negedge clk);
   endtask

   task automatic unload_serial(input sram_pkg::sram_result_t exp, input bit known0,
                                input bit known1, input int idx);
      logic [PKT_W-1:0] raw;
      raw      = exp;
      scan_bit = 1'b0;
      for (int b = PKT_W - 1; b >= 0; b--) begin
         if ((b >= DATA_W) ? known0 : known1) begin
            check_scan_bit(scan_out, raw[b], idx, b);
         end
         scan_en = 1'b1;
         @(negedge clk);
      end
      scan_en = 1'b0;
   endtask

   task automatic run_entry(input test_t t, input int idx);
      sram_pkg::sram_result_t exp;
      bit                     known0;
      bit                     known1;
      global_csb = t.gcsb;
      if (t.load_scan) begin
         load_serial(t.pkt);
      end else begin
         load_parallel(t.pkt);
      end
      start_access();
      predict(t, exp, known0, known1);
      if (t.read_scan) begin
         unload_serial(exp, known0, known1, idx);
      end else begin
         check_result(par_out, exp, known0, known1, idx);
      end
   endtask

   initial begin
      rstn       = 1'b0;
      scan_en    = 1'b0;
      scan_bit   = 1'b0;
      in_load    = 1'b0;
      par_in     = '0;
      sram_load  = 1'b0;
      global_csb = 1'b0;
      seed       = 32'h920dc84d;
      build_table();
      table_ready = 1'b1;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      // Packet register is clear out of reset
      check_result(par_out, '0, 1'b1, 1'b1, -1);
      check_scan_bit(scan_out, 1'b0, -1, PKT_W - 1);
      foreach (tbl[i]) begin
         run_entry(tbl[i], i);
      end
      $display("entries: %0d  checks: %0d  errors: %0d", tbl.size(), checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // Each entry needs at most a serial load, the access and a serial readout
   initial begin
      longint limit;
      wait (table_ready);
      limit = (longint'(tbl.size()) * (2 * PKT_W + 8) + 100) * CLK_PERIOD;
      #(limit);
      $display("watchdog: simulation did not finish within %0d ns", limit);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
